// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

    // data path and register number widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // immediate fields as carried in the instruction
    localparam int off26_w = 26;
    localparam int off16_w = 16;

    // multiplier retires one bit per cycle
    localparam int mul_steps = 32;
    localparam int mul_cnt_w = $clog2(mul_steps);

    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_and   = 4'd2,
        alu_or    = 4'd3,
        alu_xor   = 4'd4,
        alu_sll   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_slt   = 4'd8,
        alu_sltu  = 4'd9,
        alu_passb = 4'd10
    } alu_op_t;

    // memory access size
    typedef enum logic [1:0] {
        dsize_byte = 2'd0,
        dsize_half = 2'd1,
        dsize_word = 2'd2
    } dsize_t;

    // one issued instruction, as handed over by decode
    typedef struct packed {
        logic [xlen-1:0]       next_pc;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       f1;
        logic [xlen-1:0]       f2;
        logic [off26_w-1:0]    offset26;
        logic [off16_w-1:0]    offset16;
        logic [reg_addr_w-1:0] dest_reg;
        logic [reg_addr_w-1:0] fdest_reg;
        alu_op_t               alu_op;
        logic                  jump;
        logic                  branch;
        logic                  branch_zero;
        logic                  reg_to_pc;
        logic                  pc_to_reg;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  load_sign;
        logic                  mul;
        logic                  fp_reg_write;
        logic                  mov_fp2i;
        logic                  mov_i2fp;
        dsize_t                dsize;
        logic [xlen-1:0]       mem_val;
    } issue_t;

    // completed instruction on its way to memory
    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       leap_addr;
        logic [xlen-1:0]       next_pc;
        logic [xlen-1:0]       mem_val;
        logic [2*xlen-1:0]     fp_bus;
        logic                  leap;
        logic [reg_addr_w-1:0] dest_reg;
        logic [reg_addr_w-1:0] fdest_reg;
        logic                  pc_to_reg;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  load_sign;
        logic                  fp_reg_write;
        logic                  mul;
        dsize_t                dsize;
    } result_t;

endpackage

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full_q;
    payload_t data_q;

    // room when empty, or when the held item leaves this cycle
    assign in_ready  = !full_q || out_ready;
    assign out_valid = full_q;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    // loads on transfer only
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  logic [ex_pkg::xlen-1:0] a,
    input  logic [ex_pkg::xlen-1:0] b,
    input  ex_pkg::alu_op_t         op,
    output logic [ex_pkg::xlen-1:0] result,
    output logic                    zero
);

    logic [$clog2(ex_pkg::xlen)-1:0] shamt;
    logic                            lt_signed;
    logic                            lt_unsigned;

    // shift amount from the low bits of b
    assign shamt = b[$clog2(ex_pkg::xlen)-1:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ex_pkg::alu_add:   result = a + b;
            ex_pkg::alu_sub:   result = a - b;
            ex_pkg::alu_and:   result = a & b;
            ex_pkg::alu_or:    result = a | b;
            ex_pkg::alu_xor:   result = a ^ b;
            ex_pkg::alu_sll:   result = a << shamt;
            ex_pkg::alu_srl:   result = a >> shamt;
            ex_pkg::alu_sra:   result = $signed(a) >>> shamt;
            ex_pkg::alu_slt: begin
                result = {{(ex_pkg::xlen-1){1'b0}}, lt_signed};
            end
            ex_pkg::alu_sltu: begin
                result = {{(ex_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            ex_pkg::alu_passb: result = b;
            default:           result = '0;
        endcase
    end

    // branch test looks at operand a, not at the result
    assign zero = (a == '0);

endmodule

`default_nettype wire

// File: ex_mul.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mul (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [ex_pkg::xlen-1:0]   a,
    input  logic [ex_pkg::xlen-1:0]   b,
    output logic                      busy,
    output logic                      done,
    output logic [2*ex_pkg::xlen-1:0] product
);

    logic [ex_pkg::xlen-1:0]      mcand_q;
    logic [2*ex_pkg::xlen-1:0]    acc_q;
    logic [ex_pkg::mul_cnt_w-1:0] step_q;
    logic [ex_pkg::xlen:0]        partial;

    // upper half plus multiplicand when the current multiplier bit is set
    assign partial = {1'b0, acc_q[2*ex_pkg::xlen-1:ex_pkg::xlen]}
                   + (acc_q[0] ? {1'b0, mcand_q} : '0);

    assign product = acc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            step_q <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy   <= 1'b1;
                    step_q <= '0;
                end
            end else begin
                step_q <= step_q + 1'b1;
                if (int'(step_q) == ex_pkg::mul_steps - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // low half starts as the multiplier and shifts out one bit per step
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            mcand_q <= a;
            acc_q   <= {{ex_pkg::xlen{1'b0}}, b};
        end else if (busy) begin
            acc_q <= {partial, acc_q[ex_pkg::xlen-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            iss_valid,
    output logic            iss_ready,
    input  ex_pkg::issue_t  iss,
    output logic            res_valid,
    input  logic            res_ready,
    output ex_pkg::result_t res
);

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_hold
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [ex_pkg::xlen-1:0]   alu_out;
    logic                      alu_zero;
    logic [ex_pkg::xlen-1:0]   imm16_ext;
    logic [ex_pkg::xlen-1:0]   imm26_ext;
    logic [ex_pkg::xlen-1:0]   pc_target;
    logic                      mul_start;
    logic                      mul_busy;
    logic                      mul_done;
    logic [2*ex_pkg::xlen-1:0] mul_product;

    ex_alu alu_i (
        .a      (iss.op_a),
        .b      (iss.op_b),
        .op     (iss.alu_op),
        .result (alu_out),
        .zero   (alu_zero)
    );

    // fp operands; product stays put until the next start
    ex_mul mul_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .a       (iss.f1),
        .b       (iss.f2),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_product)
    );

    assign mul_start = (state_q == st_idle) && iss_valid && iss.mul && !mul_busy;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (mul_start) state_d = st_mul;
            st_mul:  if (mul_done) state_d = st_hold;
            st_hold: if (res_ready) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // non-mul items go straight through; a multiply waits for its product
    always_comb begin
        case (state_q)
            st_idle: begin
                res_valid = iss_valid && !iss.mul;
                iss_ready = res_ready && !iss.mul;
            end
            st_hold: begin
                res_valid = 1'b1;
                iss_ready = res_ready;
            end
            default: begin
                res_valid = 1'b0;
                iss_ready = 1'b0;
            end
        endcase
    end

    // sign extension of both offsets
    assign imm16_ext = {{(ex_pkg::xlen-ex_pkg::off16_w){iss.offset16[ex_pkg::off16_w-1]}},
                        iss.offset16};
    assign imm26_ext = {{(ex_pkg::xlen-ex_pkg::off26_w){iss.offset26[ex_pkg::off26_w-1]}},
                        iss.offset26};

    // branches use the short offset, jumps the long one
    assign pc_target = iss.next_pc + (iss.branch ? imm16_ext : imm26_ext);

    always_comb begin
        res.alu_result   = iss.mov_fp2i ? iss.f1 : alu_out;
        res.leap_addr    = iss.reg_to_pc ? iss.op_a : pc_target;
        res.leap         = iss.jump || (iss.branch && (alu_zero == iss.branch_zero));
        res.fp_bus       = iss.mov_i2fp ? {{ex_pkg::xlen{1'b0}}, iss.op_a} : mul_product;
        // memory and writeback control rides along untouched
        res.next_pc      = iss.next_pc;
        res.mem_val      = iss.mem_val;
        res.dest_reg     = iss.dest_reg;
        res.fdest_reg    = iss.fdest_reg;
        res.pc_to_reg    = iss.pc_to_reg;
        res.reg_write    = iss.reg_write;
        res.mem_to_reg   = iss.mem_to_reg;
        res.mem_write    = iss.mem_write;
        res.load_sign    = iss.load_sign;
        res.fp_reg_write = iss.fp_reg_write;
        res.mul          = iss.mul;
        res.dsize        = iss.dsize;
    end

endmodule

`default_nettype wire

// File: ex_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    // issue fields
    input  logic [ex_pkg::xlen-1:0]         next_pc,
    input  logic [ex_pkg::xlen-1:0]         op_a,
    input  logic [ex_pkg::xlen-1:0]         op_b,
    input  logic [ex_pkg::xlen-1:0]         f1,
    input  logic [ex_pkg::xlen-1:0]         f2,
    input  logic [ex_pkg::off26_w-1:0]      offset26,
    input  logic [ex_pkg::off16_w-1:0]      offset16,
    input  logic [ex_pkg::reg_addr_w-1:0]   dest_reg,
    input  logic [ex_pkg::reg_addr_w-1:0]   fdest_reg,
    input  ex_pkg::alu_op_t                 alu_op,
    input  logic                            jump,
    input  logic                            branch,
    input  logic                            branch_zero,
    input  logic                            reg_to_pc,
    input  logic                            pc_to_reg,
    input  logic                            reg_write,
    input  logic                            mem_to_reg,
    input  logic                            mem_write,
    input  logic                            load_sign,
    input  logic                            mul,
    input  logic                            fp_reg_write,
    input  logic                            mov_fp2i,
    input  logic                            mov_i2fp,
    input  ex_pkg::dsize_t                  dsize,
    input  logic [ex_pkg::xlen-1:0]         mem_val,
    output logic                            out_valid,
    input  logic                            out_ready,
    // result fields
    output logic [ex_pkg::xlen-1:0]         res_alu_result,
    output logic [ex_pkg::xlen-1:0]         res_leap_addr,
    output logic [ex_pkg::xlen-1:0]         res_next_pc,
    output logic [ex_pkg::xlen-1:0]         res_mem_val,
    output logic [2*ex_pkg::xlen-1:0]       res_fp_bus,
    output logic                            res_leap,
    output logic [ex_pkg::reg_addr_w-1:0]   res_dest_reg,
    output logic [ex_pkg::reg_addr_w-1:0]   res_fdest_reg,
    output logic                            res_pc_to_reg,
    output logic                            res_reg_write,
    output logic                            res_mem_to_reg,
    output logic                            res_mem_write,
    output logic                            res_load_sign,
    output logic                            res_fp_reg_write,
    output logic                            res_mul,
    output ex_pkg::dsize_t                  res_dsize
);

    ex_pkg::issue_t  in_pkt;
    ex_pkg::issue_t  iss_pkt;
    ex_pkg::result_t ex_res;
    ex_pkg::result_t out_pkt;
    logic            iss_valid;
    logic            iss_ready;
    logic            ex_valid;
    logic            ex_ready;

    assign in_pkt = '{
        next_pc:      next_pc,
        op_a:         op_a,
        op_b:         op_b,
        f1:           f1,
        f2:           f2,
        offset26:     offset26,
        offset16:     offset16,
        dest_reg:     dest_reg,
        fdest_reg:    fdest_reg,
        alu_op:       alu_op,
        jump:         jump,
        branch:       branch,
        branch_zero:  branch_zero,
        reg_to_pc:    reg_to_pc,
        pc_to_reg:    pc_to_reg,
        reg_write:    reg_write,
        mem_to_reg:   mem_to_reg,
        mem_write:    mem_write,
        load_sign:    load_sign,
        mul:          mul,
        fp_reg_write: fp_reg_write,
        mov_fp2i:     mov_fp2i,
        mov_i2fp:     mov_i2fp,
        dsize:        dsize,
        mem_val:      mem_val
    };

    stage_reg #(.payload_t(ex_pkg::issue_t)) in_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_pkt),
        .out_valid (iss_valid),
        .out_ready (iss_ready),
        .out_data  (iss_pkt)
    );

    execute exec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss       (iss_pkt),
        .res_valid (ex_valid),
        .res_ready (ex_ready),
        .res       (ex_res)
    );

    stage_reg #(.payload_t(ex_pkg::result_t)) out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_data   (ex_res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_pkt)
    );

    // unpack toward the memory stage
    assign res_alu_result   = out_pkt.alu_result;
    assign res_leap_addr    = out_pkt.leap_addr;
    assign res_next_pc      = out_pkt.next_pc;
    assign res_mem_val      = out_pkt.mem_val;
    assign res_fp_bus       = out_pkt.fp_bus;
    assign res_leap         = out_pkt.leap;
    assign res_dest_reg     = out_pkt.dest_reg;
    assign res_fdest_reg    = out_pkt.fdest_reg;
    assign res_pc_to_reg    = out_pkt.pc_to_reg;
    assign res_reg_write    = out_pkt.reg_write;
    assign res_mem_to_reg   = out_pkt.mem_to_reg;
    assign res_mem_write    = out_pkt.mem_write;
    assign res_load_sign    = out_pkt.load_sign;
    assign res_fp_reg_write = out_pkt.fp_reg_write;
    assign res_mul          = out_pkt.mul;
    assign res_dsize        = out_pkt.dsize;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: ex_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_props (
    input logic            clk,
    input logic            rst_n,
    input logic            iss_ready,
    input logic            res_valid,
    input logic            res_ready,
    input ex_pkg::result_t res,
    input logic            mul_busy
);

    // a stalled result keeps its valid and its payload
    result_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res))
    ) else $error("res or res_valid changed under back-pressure");

    // no issue is consumed while a multiply runs
    no_take_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        mul_busy |-> !iss_ready
    ) else $error("iss_ready high while the multiplier is busy");

    // reset clears the result side
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |=> !res_valid
    ) else $error("res_valid high after a reset edge");

endmodule

bind execute ex_stage_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .iss_ready (iss_ready),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .mul_busy  (mul_busy)
);

`default_nettype wire

// File: ex_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_tb;

    localparam int num_instr       = 400;
    localparam int watchdog_cycles = num_instr * (ex_pkg::mul_steps + 16);

    logic                            clk;
    logic                            rst_n;
    logic                            in_valid;
    logic                            in_ready;
    logic                            out_valid;
    logic                            out_ready;
    ex_pkg::issue_t                  drv;
    logic [ex_pkg::xlen-1:0]         res_alu_result;
    logic [ex_pkg::xlen-1:0]         res_leap_addr;
    logic [ex_pkg::xlen-1:0]         res_next_pc;
    logic [ex_pkg::xlen-1:0]         res_mem_val;
    logic [2*ex_pkg::xlen-1:0]       res_fp_bus;
    logic                            res_leap;
    logic [ex_pkg::reg_addr_w-1:0]   res_dest_reg;
    logic [ex_pkg::reg_addr_w-1:0]   res_fdest_reg;
    logic                            res_pc_to_reg;
    logic                            res_reg_write;
    logic                            res_mem_to_reg;
    logic                            res_mem_write;
    logic                            res_load_sign;
    logic                            res_fp_reg_write;
    logic                            res_mul;
    ex_pkg::dsize_t                  res_dsize;

    logic [15:0]     lfsr_q = 16'd52917;
    logic [63:0]     last_product;
    ex_pkg::result_t exp_q[$];
    int              out_count = 0;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // issue fields come from one struct and the rest match by name
    ex_stage_top dut_i (
        .*,
        .next_pc      (drv.next_pc),
        .op_a         (drv.op_a),
        .op_b         (drv.op_b),
        .f1           (drv.f1),
        .f2           (drv.f2),
        .offset26     (drv.offset26),
        .offset16     (drv.offset16),
        .dest_reg     (drv.dest_reg),
        .fdest_reg    (drv.fdest_reg),
        .alu_op       (drv.alu_op),
        .jump         (drv.jump),
        .branch       (drv.branch),
        .branch_zero  (drv.branch_zero),
        .reg_to_pc    (drv.reg_to_pc),
        .pc_to_reg    (drv.pc_to_reg),
        .reg_write    (drv.reg_write),
        .mem_to_reg   (drv.mem_to_reg),
        .mem_write    (drv.mem_write),
        .load_sign    (drv.load_sign),
        .mul          (drv.mul),
        .fp_reg_write (drv.fp_reg_write),
        .mov_fp2i     (drv.mov_fp2i),
        .mov_i2fp     (drv.mov_i2fp),
        .dsize        (drv.dsize),
        .mem_val      (drv.mem_val)
    );

    task automatic fail_run(input string why);
        $display("error: %s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s got %h expected %h", name, actual, expected);
            fail_run("DUT output differs from the model");
        end
    endtask

    // galois form with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        out_bit;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            out_bit = lfsr_q[0];
            lfsr_q  = lfsr_step(lfsr_q);
            bits    = {bits[30:0], out_bit};
        end
        return bits;
    endfunction

    function automatic ex_pkg::issue_t make_instr(input logic force_mul);
        ex_pkg::issue_t ins;
        logic [3:0]     op;
        logic [2:0]     kind;
        logic [1:0]     size;
        ins.next_pc      = take_bits(32);
        // zero operands often, so both branch senses get exercised
        ins.op_a         = (take_bits(2) == 0) ? '0 : take_bits(32);
        ins.op_b         = take_bits(32);
        ins.f1           = take_bits(32);
        ins.f2           = take_bits(32);
        ins.offset26     = 26'(take_bits(26));
        ins.offset16     = 16'(take_bits(16));
        ins.dest_reg     = 5'(take_bits(5));
        ins.fdest_reg    = 5'(take_bits(5));
        op               = 4'(take_bits(4));
        if (op > 4'd10) begin
            op = op - 4'd11;
        end
        ins.alu_op       = ex_pkg::alu_op_t'(op);
        kind             = 3'(take_bits(3));
        ins.mul          = force_mul || (kind == 3'd0);
        ins.jump         = (kind == 3'd1);
        ins.branch       = (kind == 3'd2) || (kind == 3'd3);
        ins.branch_zero  = 1'(take_bits(1));
        ins.reg_to_pc    = (take_bits(2) == 0);
        ins.pc_to_reg    = 1'(take_bits(1));
        ins.reg_write    = 1'(take_bits(1));
        ins.mem_to_reg   = 1'(take_bits(1));
        ins.mem_write    = 1'(take_bits(1));
        ins.load_sign    = 1'(take_bits(1));
        ins.fp_reg_write = 1'(take_bits(1));
        ins.mov_fp2i     = (take_bits(2) == 0);
        ins.mov_i2fp     = (take_bits(2) == 0);
        size             = 2'(take_bits(2));
        if (size == 2'd3) begin
            size = 2'd2;
        end
        ins.dsize        = ex_pkg::dsize_t'(size);
        ins.mem_val      = take_bits(32);
        return ins;
    endfunction

    // reference model of one instruction; prod is the latest multiply
    function automatic ex_pkg::result_t predict(input ex_pkg::issue_t ins,
                                                input logic [63:0] prod);
        ex_pkg::result_t r;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     alu;
        logic [31:0]     ext16;
        logic [31:0]     ext26;
        logic [4:0]      sh;
        logic            taken;
        a  = ins.op_a;
        b  = ins.op_b;
        sh = b[4:0];
        case (ins.alu_op)
            ex_pkg::alu_add:   alu = a + b;
            ex_pkg::alu_sub:   alu = a - b;
            ex_pkg::alu_and:   alu = a & b;
            ex_pkg::alu_or:    alu = a | b;
            ex_pkg::alu_xor:   alu = a ^ b;
            ex_pkg::alu_sll:   alu = a << sh;
            ex_pkg::alu_srl:   alu = a >> sh;
            ex_pkg::alu_sra:   alu = $unsigned($signed(a) >>> sh);
            ex_pkg::alu_slt:   alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::alu_sltu:  alu = (a < b) ? 32'd1 : 32'd0;
            ex_pkg::alu_passb: alu = b;
            default:           alu = '0;
        endcase
        ext16 = {{16{ins.offset16[15]}}, ins.offset16};
        ext26 = {{6{ins.offset26[25]}}, ins.offset26};
        // branch_zero picks which operand test takes the branch
        if (ins.branch_zero) begin
            taken = (a == 32'd0);
        end else begin
            taken = (a != 32'd0);
        end
        r.alu_result   = ins.mov_fp2i ? ins.f1 : alu;
        r.leap         = ins.jump || (ins.branch && taken);
        if (ins.reg_to_pc) begin
            r.leap_addr = a;
        end else begin
            r.leap_addr = ins.next_pc + (ins.branch ? ext16 : ext26);
        end
        r.fp_bus       = ins.mov_i2fp ? {32'b0, a} : prod;
        r.next_pc      = ins.next_pc;
        r.mem_val      = ins.mem_val;
        r.dest_reg     = ins.dest_reg;
        r.fdest_reg    = ins.fdest_reg;
        r.pc_to_reg    = ins.pc_to_reg;
        r.reg_write    = ins.reg_write;
        r.mem_to_reg   = ins.mem_to_reg;
        r.mem_write    = ins.mem_write;
        r.load_sign    = ins.load_sign;
        r.fp_reg_write = ins.fp_reg_write;
        r.mul          = ins.mul;
        r.dsize        = ins.dsize;
        return r;
    endfunction

    // out_ready low about a quarter of the cycles
    initial begin : ready_drive
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= rst_n && (take_bits(2) != 0);
        end
    end

    initial begin : stimulus
        ex_pkg::issue_t ins;
        int             gap;
        in_valid = 1'b0;
        drv      = '0;
        do @(negedge clk); while (!rst_n);
        check_value("out_valid", 64'(out_valid), 64'(0));
        check_value("in_ready", 64'(in_ready), 64'(1));
        for (int n = 0; n < num_instr; n++) begin
            // first item multiplies so the product register is known
            ins = make_instr(n == 0);
            gap = (take_bits(2) == 0) ? int'(take_bits(2)) + 1 : 0;
            @(posedge clk);
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            drv      <= ins;
            do @(negedge clk); while (!in_ready);
            if (ins.mul) begin
                last_product = {32'b0, ins.f1} * {32'b0, ins.f2};
            end
            exp_q.push_back(predict(ins, last_product));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (out_count < num_instr) @(negedge clk);
        repeat (4) @(negedge clk);
        if (!out_valid) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("an extra result is waiting at the output after the last instruction");
        end
    end

    // sampled mid-cycle where the handshake has settled
    always @(negedge clk) begin : scoreboard
        ex_pkg::result_t want;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("output transfer with no instruction outstanding");
            end
            want = exp_q.pop_front();
            check_value("res_alu_result", 64'(res_alu_result), 64'(want.alu_result));
            check_value("res_leap_addr", 64'(res_leap_addr), 64'(want.leap_addr));
            check_value("res_next_pc", 64'(res_next_pc), 64'(want.next_pc));
            check_value("res_mem_val", 64'(res_mem_val), 64'(want.mem_val));
            check_value("res_fp_bus", res_fp_bus, want.fp_bus);
            check_value("res_leap", 64'(res_leap), 64'(want.leap));
            check_value("res_dest_reg", 64'(res_dest_reg), 64'(want.dest_reg));
            check_value("res_fdest_reg", 64'(res_fdest_reg), 64'(want.fdest_reg));
            check_value("res_pc_to_reg", 64'(res_pc_to_reg), 64'(want.pc_to_reg));
            check_value("res_reg_write", 64'(res_reg_write), 64'(want.reg_write));
            check_value("res_mem_to_reg", 64'(res_mem_to_reg), 64'(want.mem_to_reg));
            check_value("res_mem_write", 64'(res_mem_write), 64'(want.mem_write));
            check_value("res_load_sign", 64'(res_load_sign), 64'(want.load_sign));
            check_value("res_fp_reg_write", 64'(res_fp_reg_write), 64'(want.fp_reg_write));
            check_value("res_mul", 64'(res_mul), 64'(want.mul));
            check_value("res_dsize", 64'(res_dsize), 64'(want.dsize));
            out_count = out_count + 1;
        end
    end

    // worst case every item is a multiply plus some stall cycles
    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired before all results came out");
    end

endmodule

`default_nettype wire

// File: all.f
ex_pkg.sv
stage_reg.sv
ex_alu.sv
ex_mul.sv
execute.sv
ex_stage_top.sv
tb_clk_gen.sv
ex_stage_props.sv
ex_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
